//--- verilog.f
src/mmu_pkg.sv
src/tlb_write_ctrl.sv
src/tlb_entry.sv
src/tlb_match_merge.sv
src/mmu_seg_xlate.sv
src/mmu_top.sv
verif/tb_mmu.sv

//--- verif/tb_mmu.sv
module tb_mmu;

	localparam int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES;
	localparam int TLB_IDX_W = $clog2(TLB_ENTRIES);
	localparam int CLK_HALF = 20;
	localparam int CLK_PERIOD = 2 * CLK_HALF;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 7;
	localparam int CYCLES_PER_TEST = 200;

	localparam logic [31:0] ICACHE_WORD = 32'h2400_0001;
	localparam logic [31:0] IBUS_WORD = 32'h3c1d_0002;
	localparam logic [31:0] DCACHE_WORD = 32'h1234_80f6;
	localparam logic [31:0] DBUS_WORD = 32'h5678_7f85;
	localparam logic [31:0] DPERIPH_WORD = 32'h9abc_ff7f;

	logic clk;
	logic rst_n;
	logic [31:0] ivaddr;
	logic [31:0] dvaddr;
	logic dm_en;
	logic dm_wr;
	logic [3:0] dm_bytesel;
	logic dm_unsigned;
	logic [31:0] dm_wdata;
	mmu_pkg::tlb_op_e tlb_op;
	logic [31:0] cp0_entryhi;
	logic [31:0] cp0_entrylo0;
	logic [31:0] cp0_entrylo1;
	logic [31:0] cp0_index;
	mmu_pkg::cp0_ctrl_t cp0_ctrl;
	logic [31:0] icache_data;
	logic [31:0] ibus_data;
	logic [31:0] dcache_data;
	logic [31:0] dbus_data;
	logic [31:0] dperiph_data;
	logic icache_ready;
	logic ibus_ready;
	logic dcache_ready;
	logic dbus_ready;
	logic dperiph_ready;

	logic [31:0] iphy_addr;
	logic [31:0] dphy_addr;
	logic icache_en;
	logic ibus_en;
	logic dcache_en;
	logic dbus_en;
	logic dperiph_en;
	logic [31:0] data_out;
	logic data_wr;
	logic [3:0] data_bytesel;
	logic [31:0] instruction;
	logic [31:0] dm_data;
	logic cpu_pause;
	mmu_pkg::mmu_exc_t exc;
	logic tlb_result_valid;
	logic [TLB_IDX_W-1:0] tlb_probe_index;
	logic tlb_probe_hit;
	logic [31:0] tlb_entryhi;
	logic [31:0] tlb_entrylo0;
	logic [31:0] tlb_entrylo1;

	int seed = 52;
	string cur_test;
	int test_errors;
	int error_count;
	int check_count;
	int tests_run;

	mmu_top #(
		.TLB_ENTRIES(TLB_ENTRIES)
	) dut_i (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.ivaddr_i(ivaddr),
		.dvaddr_i(dvaddr),
		.dm_en_i(dm_en),
		.dm_wr_i(dm_wr),
		.dm_bytesel_i(dm_bytesel),
		.dm_unsigned_i(dm_unsigned),
		.dm_data_i(dm_wdata),
		.tlb_op_i(tlb_op),
		.cp0_entryhi_i(cp0_entryhi),
		.cp0_entrylo0_i(cp0_entrylo0),
		.cp0_entrylo1_i(cp0_entrylo1),
		.cp0_index_i(cp0_index),
		.cp0_i(cp0_ctrl),
		.icache_data_i(icache_data),
		.ibus_data_i(ibus_data),
		.dcache_data_i(dcache_data),
		.dbus_data_i(dbus_data),
		.dperiph_data_i(dperiph_data),
		.icache_ready_i(icache_ready),
		.ibus_ready_i(ibus_ready),
		.dcache_ready_i(dcache_ready),
		.dbus_ready_i(dbus_ready),
		.dperiph_ready_i(dperiph_ready),
		.iphy_addr_o(iphy_addr),
		.dphy_addr_o(dphy_addr),
		.icache_en_o(icache_en),
		.ibus_en_o(ibus_en),
		.dcache_en_o(dcache_en),
		.dbus_en_o(dbus_en),
		.dperiph_en_o(dperiph_en),
		.data_o(data_out),
		.data_wr_o(data_wr),
		.data_bytesel_o(data_bytesel),
		.instruction_o(instruction),
		.dm_data_o(dm_data),
		.cpu_pause_o(cpu_pause),
		.exc_o(exc),
		.tlb_result_valid_o(tlb_result_valid),
		.tlb_probe_index_o(tlb_probe_index),
		.tlb_probe_hit_o(tlb_probe_hit),
		.tlb_entryhi_o(tlb_entryhi),
		.tlb_entrylo0_o(tlb_entrylo0),
		.tlb_entrylo1_o(tlb_entrylo1)
	);

	always #(CLK_HALF) clk = ~clk;

	// MIPS CP0 entryhi and entrylo layouts
	function automatic logic [31:0] make_hi(input logic [18:0] vpn2, input logic [7:0] asid);
		return {vpn2, 5'b0, asid};
	endfunction

	function automatic logic [31:0] make_lo(
		input logic [19:0] pfn,
		input logic [2:0] c,
		input logic d,
		input logic v,
		input logic g
	);
		return {6'b0, pfn, c, d, v, g};
	endfunction

	function automatic logic [31:0] extend_load(
		input logic [31:0] word,
		input logic [3:0] bytesel,
		input logic uns
	);
		if (bytesel == 4'b0001)
			return uns ? {24'b0, word[7:0]} : {{24{word[7]}}, word[7:0]};
		if (bytesel == 4'b0011)
			return uns ? {16'b0, word[15:0]} : {{16{word[15]}}, word[15:0]};
		return word;
	endfunction

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic report_test();
		tests_run++;
		if (test_errors == 0)
			$display("test %s: passed", cur_test);
		else
			$display("test %s: failed with %0d errors", cur_test, test_errors);
	endtask

	task automatic check_value(
		input string what,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		check_count++;
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, expected,
				actual);
			test_errors++;
			error_count++;
		end
	endtask

	// order is icache, ibus, dcache, dbus, dperiph
	task automatic check_enables(input string what, input logic [4:0] expected);
		check_value(what, {27'b0, expected},
			{27'b0, icache_en, ibus_en, dcache_en, dbus_en, dperiph_en});
	endtask

	task automatic check_exc(input string what, input mmu_pkg::mmu_exc_t expected);
		check_value(what, {28'b0, expected}, {28'b0, exc});
	endtask

	task automatic apply_access(
		input mmu_pkg::cp0_ctrl_t ctrl,
		input logic [31:0] iaddr,
		input logic [31:0] daddr,
		input logic en,
		input logic wr,
		input logic [3:0] bytesel,
		input logic uns
	);
		@(negedge clk);
		cp0_ctrl = ctrl;
		ivaddr = iaddr;
		dvaddr = daddr;
		dm_en = en;
		dm_wr = wr;
		dm_bytesel = bytesel;
		dm_unsigned = uns;
		// sampled halfway through the low phase
		#(CLK_HALF / 2);
	endtask

	task automatic access_word(
		input mmu_pkg::cp0_ctrl_t ctrl,
		input logic [31:0] iaddr,
		input logic [31:0] daddr
	);
		apply_access(ctrl, iaddr, daddr, 1'b1, 1'b0, 4'b1111, 1'b0);
	endtask

	task automatic set_ready(input logic [4:0] rdy);
		@(negedge clk);
		{icache_ready, ibus_ready, dcache_ready, dbus_ready, dperiph_ready} = rdy;
		#(CLK_HALF / 2);
	endtask

	// current asid comes from entryhi
	task automatic set_asid(input logic [7:0] asid);
		@(negedge clk);
		cp0_entryhi = make_hi(19'h0, asid);
	endtask

	task automatic write_indexed(
		input int idx,
		input logic [31:0] hi,
		input logic [31:0] lo0,
		input logic [31:0] lo1
	);
		@(negedge clk);
		cp0_entryhi = hi;
		cp0_entrylo0 = lo0;
		cp0_entrylo1 = lo1;
		cp0_index = idx;
		tlb_op = mmu_pkg::TLB_WRITE_INDEXED;
		@(negedge clk);
		tlb_op = mmu_pkg::TLB_NOP;
	endtask

	task automatic write_random(
		input logic [31:0] hi,
		input logic [31:0] lo0,
		input logic [31:0] lo1
	);
		@(negedge clk);
		cp0_entryhi = hi;
		cp0_entrylo0 = lo0;
		cp0_entrylo1 = lo1;
		tlb_op = mmu_pkg::TLB_WRITE_RANDOM;
		@(negedge clk);
		tlb_op = mmu_pkg::TLB_NOP;
	endtask

	task automatic probe_entry(
		input logic [31:0] hi,
		output logic valid,
		output logic hit,
		output logic [31:0] idx
	);
		@(negedge clk);
		cp0_entryhi = hi;
		tlb_op = mmu_pkg::TLB_PROBE;
		@(negedge clk);
		tlb_op = mmu_pkg::TLB_NOP;
		valid = tlb_result_valid;
		hit = tlb_probe_hit;
		idx = 32'(tlb_probe_index);
	endtask

	task automatic read_entry(
		input int idx,
		output logic valid,
		output logic [31:0] hi,
		output logic [31:0] lo0,
		output logic [31:0] lo1
	);
		@(negedge clk);
		cp0_index = idx;
		tlb_op = mmu_pkg::TLB_READ;
		@(negedge clk);
		tlb_op = mmu_pkg::TLB_NOP;
		valid = tlb_result_valid;
		hi = tlb_entryhi;
		lo0 = tlb_entrylo0;
		lo1 = tlb_entrylo1;
	endtask

	task automatic test_reset_state();
		logic valid;
		logic [31:0] hi;
		logic [31:0] lo0;
		logic [31:0] lo1;
		start_test("reset_state");
		check_value("result valid", 32'd0, {31'b0, tlb_result_valid});
		check_value("probe hit", 32'd0, {31'b0, tlb_probe_hit});
		read_entry(0, valid, hi, lo0, lo1);
		check_value("read valid", 32'd1, {31'b0, valid});
		check_value("entry 0 lo0 d/v", 32'd0, {30'b0, lo0[2:1]});
		check_value("entry 0 lo1 d/v", 32'd0, {30'b0, lo1[2:1]});
		report_test();
	endtask

	task automatic test_unmapped();
		mmu_pkg::cp0_ctrl_t ctrl;
		mmu_pkg::mmu_exc_t none;
		start_test("unmapped_segments");
		none = '0;
		ctrl = '0;
		ctrl.k0 = 3'd3;
		access_word(ctrl, 32'h8000_1234, 32'h8123_4568);
		check_value("kseg0 iphy", 32'h0000_1234, iphy_addr);
		check_value("kseg0 dphy", 32'h0123_4568, dphy_addr);
		check_enables("kseg0 cached", 5'b10100);
		check_exc("kseg0 exc", none);
		ctrl.k0 = 3'd2;
		access_word(ctrl, 32'h8000_1234, 32'h8123_4568);
		check_enables("kseg0 k0=2", 5'b01010);
		ctrl.k0 = 3'd7;
		access_word(ctrl, 32'h8000_1234, 32'h8123_4568);
		check_enables("kseg0 k0=7", 5'b01010);
		ctrl.k0 = 3'd3;
		access_word(ctrl, 32'hbfc0_0000, 32'ha000_0010);
		check_value("kseg1 iphy", 32'h1fc0_0000, iphy_addr);
		check_value("kseg1 dphy", 32'h0000_0010, dphy_addr);
		check_enables("kseg1 targets", 5'b01001);
		ctrl.erl = 1'b1;
		access_word(ctrl, 32'h0040_0000, 32'h1234_5678);
		check_value("erl iphy", 32'h0040_0000, iphy_addr);
		check_value("erl dphy", 32'h1234_5678, dphy_addr);
		check_enables("erl targets", 5'b01010);
		check_exc("erl exc", none);
		report_test();
	endtask

	task automatic test_mapped();
		mmu_pkg::cp0_ctrl_t ctrl;
		mmu_pkg::mmu_exc_t none;
		logic [19:0] pfn0;
		logic [19:0] pfn1;
		start_test("mapped_translation");
		none = '0;
		ctrl = '0;
		ctrl.k0 = 3'd3;
		pfn0 = 20'($random(seed));
		pfn1 = 20'($random(seed));
		// even page cached, odd page uncached
		write_indexed(3, make_hi(19'h00100, 8'd5), make_lo(pfn0, 3'd3, 1'b1, 1'b1, 1'b0),
			make_lo(pfn1, 3'd2, 1'b1, 1'b1, 1'b0));
		access_word(ctrl, 32'h0020_0abc, 32'h0020_1def);
		check_value("even iphy", {pfn0, 12'habc}, iphy_addr);
		check_value("odd dphy", {pfn1, 12'hdef}, dphy_addr);
		check_enables("even/odd targets", 5'b10010);
		check_exc("mapped exc", none);
		access_word(ctrl, 32'h0020_1004, 32'h0020_0ff8);
		check_value("odd iphy", {pfn1, 12'h004}, iphy_addr);
		check_value("even dphy", {pfn0, 12'hff8}, dphy_addr);
		check_enables("odd/even targets", 5'b01100);
		report_test();
	endtask

	task automatic test_exceptions();
		mmu_pkg::cp0_ctrl_t ctrl;
		mmu_pkg::mmu_exc_t expected;
		start_test("exceptions");
		ctrl = '0;
		ctrl.k0 = 3'd3;
		access_word(ctrl, 32'h0300_0000, 32'h0300_0040);
		expected = '0;
		expected.tlb_refill = 1'b1;
		check_exc("refill exc", expected);
		check_enables("refill enables", 5'b00000);
		// page0 invalid, page1 valid but clean
		write_indexed(4, make_hi(19'h00200, 8'd5), make_lo(20'h12345, 3'd3, 1'b1, 1'b0, 1'b0),
			make_lo(20'h23456, 3'd3, 1'b0, 1'b1, 1'b0));
		access_word(ctrl, 32'h0040_0100, 32'h0040_0200);
		expected = '0;
		expected.tlb_invalid = 1'b1;
		check_exc("invalid exc", expected);
		check_enables("invalid enables", 5'b00000);
		apply_access(ctrl, 32'h8000_0000, 32'h0040_1100, 1'b1, 1'b1, 4'b1111, 1'b0);
		expected = '0;
		expected.tlb_mod = 1'b1;
		check_exc("modified exc", expected);
		check_enables("modified enables", 5'b00000);
		access_word(ctrl, 32'h8000_0000, 32'h0040_1100);
		expected = '0;
		check_exc("clean load exc", expected);
		check_enables("clean load enables", 5'b10100);
		ctrl.um = 1'b1;
		access_word(ctrl, 32'h8000_0000, 32'h8000_0040);
		expected.addr_error = 1'b1;
		check_exc("address error exc", expected);
		check_enables("address error enables", 5'b00000);
		report_test();
	endtask

	task automatic test_asid_probe_read();
		mmu_pkg::cp0_ctrl_t ctrl;
		mmu_pkg::mmu_exc_t expected;
		logic [19:0] pfn [4];
		logic valid;
		logic hit;
		logic [31:0] idx;
		logic [31:0] hi;
		logic [31:0] lo0;
		logic [31:0] lo1;
		start_test("asid_probe_read");
		ctrl = '0;
		ctrl.k0 = 3'd3;
		for (int k = 0; k < 4; k++)
			pfn[k] = 20'($random(seed));
		write_indexed(6, make_hi(19'h00300, 8'd5), make_lo(pfn[0], 3'd3, 1'b1, 1'b1, 1'b0),
			make_lo(pfn[1], 3'd3, 1'b1, 1'b1, 1'b0));
		write_indexed(7, make_hi(19'h00380, 8'd9), make_lo(pfn[2], 3'd3, 1'b1, 1'b1, 1'b1),
			make_lo(pfn[3], 3'd3, 1'b1, 1'b1, 1'b1));
		set_asid(8'd5);
		access_word(ctrl, 32'h8000_0000, 32'h0060_0010);
		expected = '0;
		check_exc("own asid exc", expected);
		check_value("own asid dphy", {pfn[0], 12'h010}, dphy_addr);
		set_asid(8'd7);
		access_word(ctrl, 32'h8000_0000, 32'h0060_0010);
		expected.tlb_refill = 1'b1;
		check_exc("other asid exc", expected);
		check_enables("other asid enables", 5'b00000);
		access_word(ctrl, 32'h8000_0000, 32'h0070_1010);
		expected = '0;
		check_exc("global exc", expected);
		check_value("global dphy", {pfn[3], 12'h010}, dphy_addr);
		probe_entry(make_hi(19'h00300, 8'd5), valid, hit, idx);
		check_value("probe valid", 32'd1, {31'b0, valid});
		check_value("probe hit", 32'd1, {31'b0, hit});
		check_value("probe index", 32'd6, idx);
		@(negedge clk);
		check_value("valid after one cycle", 32'd0, {31'b0, tlb_result_valid});
		check_value("hit held", 32'd1, {31'b0, tlb_probe_hit});
		probe_entry(make_hi(19'h01800, 8'd5), valid, hit, idx);
		check_value("miss valid", 32'd1, {31'b0, valid});
		check_value("miss hit", 32'd0, {31'b0, hit});
		probe_entry(make_hi(19'h00380, 8'd3), valid, hit, idx);
		check_value("global probe hit", 32'd1, {31'b0, hit});
		check_value("global probe index", 32'd7, idx);
		read_entry(6, valid, hi, lo0, lo1);
		check_value("read valid", 32'd1, {31'b0, valid});
		check_value("read entryhi", make_hi(19'h00300, 8'd5), hi);
		check_value("read entrylo0", make_lo(pfn[0], 3'd3, 1'b1, 1'b1, 1'b0), lo0);
		check_value("read entrylo1", make_lo(pfn[1], 3'd3, 1'b1, 1'b1, 1'b0), lo1);
		read_entry(7, valid, hi, lo0, lo1);
		check_value("read global entryhi", make_hi(19'h00380, 8'd9), hi);
		check_value("read global entrylo0", make_lo(pfn[2], 3'd3, 1'b1, 1'b1, 1'b1), lo0);
		report_test();
	endtask

	task automatic test_random_replacement();
		logic [18:0] vpn2;
		logic valid;
		logic hit;
		logic [31:0] idx;
		start_test("random_replacement");
		for (int k = 0; k < 3; k++)
		begin
			vpn2 = 19'h00400 + 19'(16 * k);
			write_random(make_hi(vpn2, 8'd5),
				make_lo(20'($random(seed)), 3'd3, 1'b1, 1'b1, 1'b0),
				make_lo(20'($random(seed)), 3'd3, 1'b1, 1'b1, 1'b0));
		end
		for (int k = 0; k < 3; k++)
		begin
			vpn2 = 19'h00400 + 19'(16 * k);
			probe_entry(make_hi(vpn2, 8'd5), valid, hit, idx);
			check_value($sformatf("wr %0d hit", k), 32'd1, {31'b0, hit});
			check_value($sformatf("wr %0d index", k), 32'(TLB_ENTRIES - 1 - k), idx);
		end
		report_test();
	endtask

	task automatic test_data_pause();
		mmu_pkg::cp0_ctrl_t ctrl;
		logic [31:0] words [3];
		logic [31:0] addrs [3];
		logic [2:0] k0s [3];
		logic [3:0] sels [3];
		logic [31:0] store_word;
		start_test("data_pause");
		ctrl = '0;
		words[0] = DCACHE_WORD;
		words[1] = DBUS_WORD;
		words[2] = DPERIPH_WORD;
		addrs[0] = 32'h8000_0100;
		addrs[1] = 32'h8000_0100;
		addrs[2] = 32'ha000_0100;
		k0s[0] = 3'd3;
		k0s[1] = 3'd2;
		k0s[2] = 3'd3;
		sels[0] = 4'b1111;
		sels[1] = 4'b0001;
		sels[2] = 4'b0011;
		for (int s = 0; s < 3; s++)
			for (int b = 0; b < 3; b++)
				for (int u = 0; u < 2; u++)
				begin
					ctrl.k0 = k0s[s];
					apply_access(ctrl, 32'h8000_0000, addrs[s], 1'b1, 1'b0, sels[b], u[0]);
					check_value($sformatf("load src %0d sel %b uns %0d", s, sels[b], u),
						extend_load(words[s], sels[b], u[0]), dm_data);
				end
		ctrl.k0 = 3'd3;
		// store data and strobes pass beside the address
		store_word = $random(seed);
		@(negedge clk);
		dm_wdata = store_word;
		apply_access(ctrl, 32'h8000_0000, 32'h8000_0200, 1'b1, 1'b1, 4'b0011, 1'b0);
		check_value("store data", store_word, data_out);
		check_value("store write", 32'd1, {31'b0, data_wr});
		check_value("store bytesel", 32'h3, {28'b0, data_bytesel});
		access_word(ctrl, 32'h8000_0000, 32'h8000_0100);
		check_value("cached fetch", ICACHE_WORD, instruction);
		check_value("all ready pause", 32'd0, {31'b0, cpu_pause});
		check_value("load write", 32'd0, {31'b0, data_wr});
		access_word(ctrl, 32'hbfc0_0000, 32'h8000_0100);
		check_value("uncached fetch", IBUS_WORD, instruction);
		access_word(ctrl, 32'h8000_0000, 32'h8000_0100);
		set_ready(5'b11011);
		check_value("dcache busy pause", 32'd1, {31'b0, cpu_pause});
		set_ready(5'b11101);
		check_value("unselected busy pause", 32'd0, {31'b0, cpu_pause});
		set_ready(5'b01111);
		check_value("icache busy pause", 32'd1, {31'b0, cpu_pause});
		set_ready(5'b11110);
		access_word(ctrl, 32'h8000_0000, 32'ha000_0100);
		check_value("periph busy pause", 32'd1, {31'b0, cpu_pause});
		apply_access(ctrl, 32'h8000_0000, 32'ha000_0100, 1'b0, 1'b0, 4'b1111, 1'b0);
		check_value("no access pause", 32'd0, {31'b0, cpu_pause});
		set_ready(5'b11111);
		report_test();
	endtask

	// watchdog sized from the test count
	initial
	begin
		#((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
		$display("watchdog expired: tests did not finish in time, stopped in %s", cur_test);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		ivaddr = '0;
		dvaddr = '0;
		dm_en = 1'b0;
		dm_wr = 1'b0;
		dm_bytesel = 4'b1111;
		dm_unsigned = 1'b0;
		dm_wdata = '0;
		tlb_op = mmu_pkg::TLB_NOP;
		cp0_entryhi = '0;
		cp0_entrylo0 = '0;
		cp0_entrylo1 = '0;
		cp0_index = '0;
		cp0_ctrl = '0;
		icache_data = ICACHE_WORD;
		ibus_data = IBUS_WORD;
		dcache_data = DCACHE_WORD;
		dbus_data = DBUS_WORD;
		dperiph_data = DPERIPH_WORD;
		{icache_ready, ibus_ready, dcache_ready, dbus_ready, dperiph_ready} = 5'b11111;
		cur_test = "reset";
		test_errors = 0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset_state();
		test_unmapped();
		test_mapped();
		test_exceptions();
		test_asid_probe_read();
		test_random_replacement();
		test_data_pause();
		$display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- src/mmu_top.sv
module mmu_top #(
	parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES,
	localparam int TLB_IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic [31:0] ivaddr_i,
	input  logic [31:0] dvaddr_i,
	input  logic dm_en_i,
	input  logic dm_wr_i,
	input  logic [3:0] dm_bytesel_i,
	input  logic dm_unsigned_i,
	input  logic [31:0] dm_data_i,
	input  mmu_pkg::tlb_op_e tlb_op_i,
	input  logic [31:0] cp0_entryhi_i,
	input  logic [31:0] cp0_entrylo0_i,
	input  logic [31:0] cp0_entrylo1_i,
	input  logic [31:0] cp0_index_i,
	input  mmu_pkg::cp0_ctrl_t cp0_i,
	input  logic [31:0] icache_data_i,
	input  logic [31:0] ibus_data_i,
	input  logic [31:0] dcache_data_i,
	input  logic [31:0] dbus_data_i,
	input  logic [31:0] dperiph_data_i,
	input  logic icache_ready_i,
	input  logic ibus_ready_i,
	input  logic dcache_ready_i,
	input  logic dbus_ready_i,
	input  logic dperiph_ready_i,
	output logic [31:0] iphy_addr_o,
	output logic [31:0] dphy_addr_o,
	output logic icache_en_o,
	output logic ibus_en_o,
	output logic dcache_en_o,
	output logic dbus_en_o,
	output logic dperiph_en_o,
	output logic [31:0] data_o,
	output logic data_wr_o,
	output logic [3:0] data_bytesel_o,
	output logic [31:0] instruction_o,
	output logic [31:0] dm_data_o,
	output logic cpu_pause_o,
	output mmu_pkg::mmu_exc_t exc_o,
	output logic tlb_result_valid_o,
	output logic [TLB_IDX_W-1:0] tlb_probe_index_o,
	output logic tlb_probe_hit_o,
	output logic [31:0] tlb_entryhi_o,
	output logic [31:0] tlb_entrylo0_o,
	output logic [31:0] tlb_entrylo1_o
);

	mmu_pkg::tlb_entry_t wr_entry;
	mmu_pkg::tlb_entry_t read_entry;
	mmu_pkg::tlb_entry_t entries [TLB_ENTRIES];
	logic [TLB_ENTRIES-1:0] wr_en;
	logic [TLB_ENTRIES-1:0] imatch;
	logic [TLB_ENTRIES-1:0] dmatch;
	logic [TLB_ENTRIES-1:0] pmatch;
	logic [TLB_IDX_W-1:0] sel_index;
	mmu_pkg::tlb_lookup_t ilookup;
	mmu_pkg::tlb_lookup_t dlookup;
	mmu_pkg::mem_target_e itarget;
	mmu_pkg::mem_target_e dtarget;

	// entrylo[25:1] lines up with tlb_page_t
	always_comb
	begin
		wr_entry.vpn2 = cp0_entryhi_i[31:13];
		wr_entry.asid = cp0_entryhi_i[7:0];
		wr_entry.g = cp0_entrylo0_i[0] & cp0_entrylo1_i[0];
		wr_entry.page0 = mmu_pkg::tlb_page_t'(cp0_entrylo0_i[25:1]);
		wr_entry.page1 = mmu_pkg::tlb_page_t'(cp0_entrylo1_i[25:1]);
	end

	tlb_write_ctrl #(
		.TLB_ENTRIES(TLB_ENTRIES)
	) u_write_ctrl (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.tlb_op_i(tlb_op_i),
		.cp0_index_i(cp0_index_i[TLB_IDX_W-1:0]),
		.wr_en_o(wr_en),
		.sel_index_o(sel_index)
	);

	for (genvar k = 0; k < TLB_ENTRIES; k++)
	begin : g_entry
		tlb_entry u_entry (
			.clk_i(clk_i),
			.rst_n_i(rst_n_i),
			.wr_en_i(wr_en[k]),
			.entry_i(wr_entry),
			.ivpn2_i(ivaddr_i[31:13]),
			.dvpn2_i(dvaddr_i[31:13]),
			.pvpn2_i(cp0_entryhi_i[31:13]),
			.asid_i(cp0_entryhi_i[7:0]),
			.pasid_i(cp0_entryhi_i[7:0]),
			.entry_o(entries[k]),
			.imatch_o(imatch[k]),
			.dmatch_o(dmatch[k]),
			.pmatch_o(pmatch[k])
		);
	end

	tlb_match_merge #(
		.TLB_ENTRIES(TLB_ENTRIES)
	) u_match_merge (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.tlb_op_i(tlb_op_i),
		.sel_index_i(sel_index),
		.entries_i(entries),
		.imatch_i(imatch),
		.dmatch_i(dmatch),
		.pmatch_i(pmatch),
		.iodd_i(ivaddr_i[12]),
		.dodd_i(dvaddr_i[12]),
		.ilookup_o(ilookup),
		.dlookup_o(dlookup),
		.tlb_result_valid_o(tlb_result_valid_o),
		.probe_index_o(tlb_probe_index_o),
		.probe_hit_o(tlb_probe_hit_o),
		.read_entry_o(read_entry)
	);

	mmu_seg_xlate u_seg_xlate (
		.ivaddr_i(ivaddr_i),
		.dvaddr_i(dvaddr_i),
		.dm_en_i(dm_en_i),
		.dm_wr_i(dm_wr_i),
		.dm_bytesel_i(dm_bytesel_i),
		.dm_unsigned_i(dm_unsigned_i),
		.cp0_i(cp0_i),
		.ilookup_i(ilookup),
		.dlookup_i(dlookup),
		.icache_data_i(icache_data_i),
		.ibus_data_i(ibus_data_i),
		.dcache_data_i(dcache_data_i),
		.dbus_data_i(dbus_data_i),
		.dperiph_data_i(dperiph_data_i),
		.icache_ready_i(icache_ready_i),
		.ibus_ready_i(ibus_ready_i),
		.dcache_ready_i(dcache_ready_i),
		.dbus_ready_i(dbus_ready_i),
		.dperiph_ready_i(dperiph_ready_i),
		.iphy_addr_o(iphy_addr_o),
		.dphy_addr_o(dphy_addr_o),
		.itarget_o(itarget),
		.dtarget_o(dtarget),
		.exc_o(exc_o),
		.instruction_o(instruction_o),
		.dm_data_o(dm_data_o),
		.cpu_pause_o(cpu_pause_o)
	);

	assign icache_en_o = (itarget == mmu_pkg::TGT_CACHE);
	assign ibus_en_o = (itarget == mmu_pkg::TGT_MEMORY);
	assign dcache_en_o = (dtarget == mmu_pkg::TGT_CACHE);
	assign dbus_en_o = (dtarget == mmu_pkg::TGT_MEMORY);
	assign dperiph_en_o = (dtarget == mmu_pkg::TGT_PERIPH);

	// store data goes out beside the address
	assign data_o = dm_data_i;
	assign data_wr_o = dm_wr_i;
	assign data_bytesel_o = dm_bytesel_i;

	assign tlb_entryhi_o = {read_entry.vpn2, 5'b0, read_entry.asid};
	assign tlb_entrylo0_o = {6'b0, read_entry.page0, read_entry.g};
	assign tlb_entrylo1_o = {6'b0, read_entry.page1, read_entry.g};

endmodule

//--- src/mmu_seg_xlate.sv
module mmu_seg_xlate (
	input  logic [31:0] ivaddr_i,
	input  logic [31:0] dvaddr_i,
	input  logic dm_en_i,
	input  logic dm_wr_i,
	input  logic [3:0] dm_bytesel_i,
	input  logic dm_unsigned_i,
	input  mmu_pkg::cp0_ctrl_t cp0_i,
	input  mmu_pkg::tlb_lookup_t ilookup_i,
	input  mmu_pkg::tlb_lookup_t dlookup_i,
	input  logic [31:0] icache_data_i,
	input  logic [31:0] ibus_data_i,
	input  logic [31:0] dcache_data_i,
	input  logic [31:0] dbus_data_i,
	input  logic [31:0] dperiph_data_i,
	input  logic icache_ready_i,
	input  logic ibus_ready_i,
	input  logic dcache_ready_i,
	input  logic dbus_ready_i,
	input  logic dperiph_ready_i,
	output logic [31:0] iphy_addr_o,
	output logic [31:0] dphy_addr_o,
	output mmu_pkg::mem_target_e itarget_o,
	output mmu_pkg::mem_target_e dtarget_o,
	output mmu_pkg::mmu_exc_t exc_o,
	output logic [31:0] instruction_o,
	output logic [31:0] dm_data_o,
	output logic cpu_pause_o
);

	logic user_mode;
	mmu_pkg::mmu_exc_t iexc;
	mmu_pkg::mmu_exc_t dexc_raw;
	mmu_pkg::mmu_exc_t dexc;
	mmu_pkg::mem_target_e itgt_raw;
	mmu_pkg::mem_target_e dtgt_raw;
	logic [31:0] dword;
	logic iready;
	logic dready;

	function automatic mmu_pkg::mem_target_e cattr(input logic [2:0] c);
		if (c == mmu_pkg::CCA_UNCACHED || c == mmu_pkg::CCA_UNCACHED_ALT)
			return mmu_pkg::TGT_MEMORY;
		return mmu_pkg::TGT_CACHE;
	endfunction

	function automatic void xlate(
		input logic [31:0] vaddr,
		input mmu_pkg::tlb_lookup_t lookup,
		input logic is_data,
		input logic is_store,
		input logic umode,
		input mmu_pkg::cp0_ctrl_t cp0,
		output logic [31:0] phy,
		output mmu_pkg::mem_target_e tgt,
		output mmu_pkg::mmu_exc_t exc
	);
		exc = '0;
		tgt = mmu_pkg::TGT_NONE;
		phy = vaddr;
		case (vaddr[31:29])
			3'b100:
			begin
				phy = {3'b000, vaddr[28:0]};
				tgt = cattr(cp0.k0);
			end
			3'b101:
			begin
				phy = {3'b000, vaddr[28:0]};
				tgt = is_data ? mmu_pkg::TGT_PERIPH : mmu_pkg::TGT_MEMORY;
			end
			default:
			begin
				// erl leaves kuseg unmapped and uncached
				if (cp0.erl && !vaddr[31])
					tgt = mmu_pkg::TGT_MEMORY;
				else
				begin
					phy = {lookup.page.pfn, vaddr[11:0]};
					if (!lookup.hit)
						exc.tlb_refill = 1'b1;
					else if (!lookup.page.v)
						exc.tlb_invalid = 1'b1;
					else if (is_store && !lookup.page.d)
						exc.tlb_mod = 1'b1;
					else
						tgt = cattr(lookup.page.c);
				end
			end
		endcase
		// address error outranks every tlb fault
		if (umode && vaddr[31])
		begin
			exc = '0;
			exc.addr_error = 1'b1;
		end
	endfunction

	assign user_mode = !cp0_i.erl && !cp0_i.exl && cp0_i.um;

	always_comb
	begin
		xlate(ivaddr_i, ilookup_i, 1'b0, 1'b0, user_mode, cp0_i, iphy_addr_o, itgt_raw, iexc);
	end

	always_comb
	begin
		xlate(dvaddr_i, dlookup_i, 1'b1, dm_wr_i, user_mode, cp0_i, dphy_addr_o, dtgt_raw, dexc_raw);
	end

	// no data access, no data faults
	assign dexc = dm_en_i ? dexc_raw : '0;

	assign exc_o.addr_error = iexc.addr_error | dexc.addr_error;
	assign exc_o.tlb_refill = iexc.tlb_refill | dexc.tlb_refill;
	assign exc_o.tlb_invalid = iexc.tlb_invalid | dexc.tlb_invalid;
	assign exc_o.tlb_mod = iexc.tlb_mod | dexc.tlb_mod;

	// any fault cancels both accesses
	assign itarget_o = (exc_o != '0) ? mmu_pkg::TGT_NONE : itgt_raw;
	assign dtarget_o = (dm_en_i && exc_o == '0) ? dtgt_raw : mmu_pkg::TGT_NONE;

	always_comb
	begin
		case (itarget_o)
			mmu_pkg::TGT_CACHE:
			begin
				instruction_o = icache_data_i;
				iready = icache_ready_i;
			end
			mmu_pkg::TGT_MEMORY:
			begin
				instruction_o = ibus_data_i;
				iready = ibus_ready_i;
			end
			default:
			begin
				instruction_o = '0;
				iready = 1'b1;
			end
		endcase
	end

	always_comb
	begin
		case (dtarget_o)
			mmu_pkg::TGT_CACHE:
			begin
				dword = dcache_data_i;
				dready = dcache_ready_i;
			end
			mmu_pkg::TGT_MEMORY:
			begin
				dword = dbus_data_i;
				dready = dbus_ready_i;
			end
			mmu_pkg::TGT_PERIPH:
			begin
				dword = dperiph_data_i;
				dready = dperiph_ready_i;
			end
			default:
			begin
				dword = '0;
				dready = 1'b1;
			end
		endcase
	end

	// byte and halfword loads arrive right aligned
	always_comb
	begin
		case (dm_bytesel_i)
			4'b0001: dm_data_o = {{24{!dm_unsigned_i & dword[7]}}, dword[7:0]};
			4'b0011: dm_data_o = {{16{!dm_unsigned_i & dword[15]}}, dword[15:0]};
			default: dm_data_o = dword;
		endcase
	end

	assign cpu_pause_o = !iready || (dm_en_i && !dready);

endmodule

//--- src/tlb_match_merge.sv
module tlb_match_merge #(
	parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES,
	localparam int TLB_IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic clk_i,
	input  logic rst_n_i,
	input  mmu_pkg::tlb_op_e tlb_op_i,
	input  logic [TLB_IDX_W-1:0] sel_index_i,
	input  mmu_pkg::tlb_entry_t entries_i [TLB_ENTRIES],
	input  logic [TLB_ENTRIES-1:0] imatch_i,
	input  logic [TLB_ENTRIES-1:0] dmatch_i,
	input  logic [TLB_ENTRIES-1:0] pmatch_i,
	input  logic iodd_i,
	input  logic dodd_i,
	output mmu_pkg::tlb_lookup_t ilookup_o,
	output mmu_pkg::tlb_lookup_t dlookup_o,
	output logic tlb_result_valid_o,
	output logic [TLB_IDX_W-1:0] probe_index_o,
	output logic probe_hit_o,
	output mmu_pkg::tlb_entry_t read_entry_o
);

	logic [TLB_IDX_W-1:0] probe_idx;

	// odd selects the page of the pair
	function automatic mmu_pkg::tlb_lookup_t pick(
		input logic [TLB_ENTRIES-1:0] match,
		input logic odd,
		input mmu_pkg::tlb_entry_t ents [TLB_ENTRIES]
	);
		mmu_pkg::tlb_lookup_t res;
		res = '0;
		for (int k = 0; k < TLB_ENTRIES; k++)
		begin
			if (match[k])
			begin
				res.hit = 1'b1;
				res.page = odd ? ents[k].page1 : ents[k].page0;
			end
		end
		return res;
	endfunction

	assign ilookup_o = pick(imatch_i, iodd_i, entries_i);
	assign dlookup_o = pick(dmatch_i, dodd_i, entries_i);

	always_comb
	begin
		probe_idx = '0;
		for (int k = 0; k < TLB_ENTRIES; k++)
		begin
			if (pmatch_i[k])
				probe_idx = TLB_IDX_W'(k);
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			tlb_result_valid_o <= 1'b0;
			probe_hit_o <= 1'b0;
			probe_index_o <= '0;
		end
		else
		begin
			tlb_result_valid_o <= (tlb_op_i == mmu_pkg::TLB_PROBE) ||
				(tlb_op_i == mmu_pkg::TLB_READ);
			if (tlb_op_i == mmu_pkg::TLB_PROBE)
			begin
				probe_hit_o <= |pmatch_i;
				probe_index_o <= probe_idx;
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (tlb_op_i == mmu_pkg::TLB_READ)
			read_entry_o <= entries_i[sel_index_i];
	end

	// duplicate entries would be a machine check
	imatch_onehot_a: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) $onehot0(imatch_i));
	dmatch_onehot_a: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) $onehot0(dmatch_i));
	pmatch_onehot_a: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) $onehot0(pmatch_i));

endmodule

//--- src/tlb_entry.sv
module tlb_entry (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic wr_en_i,
	input  mmu_pkg::tlb_entry_t entry_i,
	input  logic [mmu_pkg::VPN2_W-1:0] ivpn2_i,
	input  logic [mmu_pkg::VPN2_W-1:0] dvpn2_i,
	input  logic [mmu_pkg::VPN2_W-1:0] pvpn2_i,
	input  logic [mmu_pkg::ASID_W-1:0] asid_i,
	input  logic [mmu_pkg::ASID_W-1:0] pasid_i,
	output mmu_pkg::tlb_entry_t entry_o,
	output logic imatch_o,
	output logic dmatch_o,
	output logic pmatch_o
);

	mmu_pkg::tlb_entry_t entry_q;
	logic used_q;
	logic [1:0] valid_q;
	logic [1:0] dirty_q;
	logic asid_ok;
	logic pasid_ok;

	always_ff @(posedge clk_i)
	begin
		if (wr_en_i)
			entry_q <= entry_i;
	end

	// used_q keeps a never-written entry out of every compare
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			used_q <= 1'b0;
			valid_q <= 2'b00;
			dirty_q <= 2'b00;
		end
		else if (wr_en_i)
		begin
			used_q <= 1'b1;
			valid_q <= {entry_i.page1.v, entry_i.page0.v};
			dirty_q <= {entry_i.page1.d, entry_i.page0.d};
		end
	end

	always_comb
	begin
		entry_o = entry_q;
		entry_o.page0.v = valid_q[0];
		entry_o.page0.d = dirty_q[0];
		entry_o.page1.v = valid_q[1];
		entry_o.page1.d = dirty_q[1];
	end

	// global entries ignore the asid
	assign asid_ok = entry_q.g || (entry_q.asid == asid_i);
	assign pasid_ok = entry_q.g || (entry_q.asid == pasid_i);

	assign imatch_o = used_q && asid_ok && (entry_q.vpn2 == ivpn2_i);
	assign dmatch_o = used_q && asid_ok && (entry_q.vpn2 == dvpn2_i);
	assign pmatch_o = used_q && pasid_ok && (entry_q.vpn2 == pvpn2_i);

endmodule

//--- src/tlb_write_ctrl.sv
module tlb_write_ctrl #(
	parameter int TLB_ENTRIES = mmu_pkg::TLB_ENTRIES,
	localparam int TLB_IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic clk_i,
	input  logic rst_n_i,
	input  mmu_pkg::tlb_op_e tlb_op_i,
	input  logic [TLB_IDX_W-1:0] cp0_index_i,
	output logic [TLB_ENTRIES-1:0] wr_en_o,
	output logic [TLB_IDX_W-1:0] sel_index_o
);

	logic [TLB_IDX_W-1:0] rnd_q;
	logic is_random;
	logic is_write;

	assign is_random = (tlb_op_i == mmu_pkg::TLB_WRITE_RANDOM);
	assign is_write = is_random || (tlb_op_i == mmu_pkg::TLB_WRITE_INDEXED);

	// read and indexed write both use the CP0 index
	assign sel_index_o = is_random ? rnd_q : cp0_index_i;

	always_comb
	begin
		wr_en_o = '0;
		if (is_write)
			wr_en_o[sel_index_o] = 1'b1;
	end

	// replacement pointer walks down from the top entry
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			rnd_q <= TLB_IDX_W'(TLB_ENTRIES - 1);
		else if (is_random)
		begin
			if (rnd_q == '0)
				rnd_q <= TLB_IDX_W'(TLB_ENTRIES - 1);
			else
				rnd_q <= rnd_q - 1'b1;
		end
	end

	// one existing entry per write op, none otherwise
	wr_en_onehot_a: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0(wr_en_o) && (is_write == (|wr_en_o))
	);

endmodule

//--- src/mmu_pkg.sv
package mmu_pkg;

	// default TLB depth, overridden from the top level
	localparam int TLB_ENTRIES = 16;

	localparam int VPN2_W = 19;
	localparam int ASID_W = 8;
	localparam int PFN_W = 20;

	// cache attributes that bypass the cache
	localparam logic [2:0] CCA_UNCACHED = 3'd2;
	localparam logic [2:0] CCA_UNCACHED_ALT = 3'd7;

	// same bit order as entrylo[25:1]
	typedef struct packed {
		logic [PFN_W-1:0] pfn;
		logic [2:0] c;
		logic d;
		logic v;
	} tlb_page_t;

	typedef struct packed {
		logic [VPN2_W-1:0] vpn2;
		logic [ASID_W-1:0] asid;
		logic g;
		tlb_page_t page0;
		tlb_page_t page1;
	} tlb_entry_t;

	typedef struct packed {
		logic hit;
		tlb_page_t page;
	} tlb_lookup_t;

	typedef struct packed {
		logic erl;
		logic exl;
		logic um;
		logic [2:0] k0;
	} cp0_ctrl_t;

	typedef struct packed {
		logic addr_error;
		logic tlb_refill;
		logic tlb_invalid;
		logic tlb_mod;
	} mmu_exc_t;

	typedef enum logic [2:0] {
		TLB_NOP = 3'd0,
		TLB_PROBE = 3'd1,
		TLB_READ = 3'd2,
		TLB_WRITE_INDEXED = 3'd3,
		TLB_WRITE_RANDOM = 3'd4
	} tlb_op_e;

	typedef enum logic [1:0] {
		TGT_NONE = 2'd0,
		TGT_CACHE = 2'd1,
		TGT_MEMORY = 2'd2,
		TGT_PERIPH = 2'd3
	} mem_target_e;

endpackage
